//--- verilog/ql_cfg_pkg.sv
package ql_cfg_pkg;

	// ========================================
	// Build time options
	// ========================================

	typedef enum logic [1:0] {
		RAM_128K,	// Stock QL
		RAM_640K,
		RAM_896K,
		RAM_4096K	// GoldCard mode
	} ram_cfg_e;

	typedef enum logic [1:0] {
		SPEED_QL,	// Original 68008 bus rate
		SPEED_16,
		SPEED_24,
		SPEED_FULL
	} cpu_speed_e;

	// Dividers for an 84 MHz clk_sys
	localparam int DIV_BUS_QL_DEF   = 11;	// 7.64 MHz
	localparam int DIV_BUS_16_DEF   = 5;	// 16.8 MHz
	localparam int DIV_BUS_24_DEF   = 3;	// 28 MHz, close enough
	localparam int DIV_BUS_FULL_DEF = 2;	// 42 MHz
	localparam int DIV_131K_DEF     = 640;	// 131.25 kHz refresh and RTC tick
	localparam int DIV_VID_DEF      = 8;	// 10.5 MHz pixel rate

endpackage

//--- verilog/ql_map_pkg.sv
package ql_map_pkg;

	localparam int ADDR_W = 24;	// 68008 byte address
	localparam int DATA_W = 16;

	typedef enum logic [3:0] {
		REG_NONE,
		REG_OS_ROM,		// $0000-$BFFF
		REG_EXT_ROM,	// $C000-$FFFF
		REG_QLSD_REG,	// $FEE0-$FEFF, reads only
		REG_QLSD_DAT,	// $FF00-$FFFF, reads only
		REG_RAM,
		REG_QL_IO,
		REG_GC_IO,
		REG_GC_BOOT,
		REG_GC_OS_ROM
	} ql_region_e;

	// ========================================
	// Address ranges
	// ========================================

	// Wrap masks per RAM size
	localparam logic [ADDR_W-1:0] MASK_128K = 24'h03FFFF;	// 256 KB
	localparam logic [ADDR_W-1:0] MASK_1M   = 24'h0FFFFF;
	localparam logic [ADDR_W-1:0] MASK_8M   = 24'h7FFFFF;	// Room for GC extras

	localparam logic [ADDR_W-1:0] EXT_ROM_BASE  = 24'h00C000;	// Also OS ROM size
	localparam logic [ADDR_W-1:0] EXT_ROM_SIZE  = 24'h004000;
	localparam logic [ADDR_W-1:0] QLSD_REG_BASE = 24'h00FEE0;
	localparam logic [ADDR_W-1:0] QLSD_REG_SIZE = 24'h000020;
	localparam logic [ADDR_W-1:0] QLSD_DAT_BASE = 24'h00FF00;
	localparam logic [ADDR_W-1:0] QLSD_DAT_SIZE = 24'h000100;
	localparam logic [ADDR_W-1:0] QLSD_RD_ADDR  = 24'h00FEE4;	// Only reg with read data

	localparam logic [ADDR_W-1:0] QL_IO_BASE = 24'h018000;
	localparam logic [ADDR_W-1:0] QL_IO_SIZE = 24'h004000;
	localparam logic [ADDR_W-1:0] VRAM_BASE  = 24'h020000;	// Screen 0 and 1
	localparam logic [ADDR_W-1:0] VRAM_SIZE  = 24'h010000;
	localparam logic [ADDR_W-1:0] BRAM_BASE  = 24'h020000;	// Base 128k
	localparam logic [ADDR_W-1:0] BRAM_SIZE  = 24'h020000;

	// Extended RAM, end is exclusive
	localparam logic [ADDR_W-1:0] XRAM_BASE      = 24'h040000;
	localparam logic [ADDR_W-1:0] XRAM_END_640K  = 24'h0C0000;
	localparam logic [ADDR_W-1:0] XRAM_END_896K  = 24'h100000;
	localparam logic [ADDR_W-1:0] XRAM_END_4096K = 24'h400000;

	// GoldCard extras
	localparam logic [ADDR_W-1:0] GC_RAM1_BASE = 24'h010000;
	localparam logic [ADDR_W-1:0] GC_RAM1_SIZE = 24'h008000;
	localparam logic [ADDR_W-1:0] GC_IO_BASE   = 24'h01C000;
	localparam logic [ADDR_W-1:0] GC_IO_SIZE   = 24'h000100;
	localparam logic [ADDR_W-1:0] GC_RAM2_BASE = 24'h01C100;
	localparam logic [ADDR_W-1:0] GC_RAM2_SIZE = 24'h003F00;
	localparam logic [ADDR_W-1:0] GC_BOOT_BASE = 24'h040000;
	localparam logic [ADDR_W-1:0] GC_BOOT_SIZE = 24'h010000;
	localparam logic [ADDR_W-1:0] GC_OS_BASE   = 24'h400000;
	localparam logic [ADDR_W-1:0] GC_OS_SIZE   = 24'h010000;

endpackage

//--- verilog/ql_clock_enables.sv
module ql_clock_enables #(
	parameter int DIV_BUS_QL   = ql_cfg_pkg::DIV_BUS_QL_DEF,
	parameter int DIV_BUS_16   = ql_cfg_pkg::DIV_BUS_16_DEF,
	parameter int DIV_BUS_24   = ql_cfg_pkg::DIV_BUS_24_DEF,
	parameter int DIV_BUS_FULL = ql_cfg_pkg::DIV_BUS_FULL_DEF,
	parameter int DIV_131K     = ql_cfg_pkg::DIV_131K_DEF,
	parameter int DIV_VID      = ql_cfg_pkg::DIV_VID_DEF
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_cfg_pkg::cpu_speed_e cpu_speed,
	output logic                   ce_bus_p,	// Phi1
	output logic                   ce_bus_n,	// Phi2
	output logic                   ce_131k,
	output logic                   ce_vid
);
	import ql_cfg_pkg::*;

	localparam int BUS_W = $clog2(DIV_BUS_QL + 1);	// QL rate is the slowest
	localparam int SLOW_W = $clog2(DIV_131K + 1);
	localparam int VID_W = $clog2(DIV_VID + 1);

	logic [BUS_W-1:0] div_bus;
	logic [BUS_W-1:0] bus_div;	// Period for current speed
	logic [SLOW_W-1:0] div_131k;
	logic [VID_W-1:0] div_vid;

	always_comb begin
		unique case (cpu_speed)
			SPEED_QL:   bus_div = BUS_W'(DIV_BUS_QL);
			SPEED_16:   bus_div = BUS_W'(DIV_BUS_16);
			SPEED_24:   bus_div = BUS_W'(DIV_BUS_24);
			SPEED_FULL: bus_div = BUS_W'(DIV_BUS_FULL);
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_bus <= '0;
			div_131k <= '0;
			div_vid <= '0;
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
			ce_131k <= 1'b0;
			ce_vid <= 1'b0;
		end else begin
			// >= catches a count left above the wrap by a speed change
			div_bus <= (div_bus >= bus_div - 1'b1) ? '0 : div_bus + 1'b1;
			div_131k <= (div_131k == SLOW_W'(DIV_131K - 1)) ? '0 : div_131k + 1'b1;
			div_vid <= (div_vid == VID_W'(DIV_VID - 1)) ? '0 : div_vid + 1'b1;
			ce_bus_p <= div_bus == '0;
			ce_bus_n <= div_bus == (bus_div >> 1);	// Half a bus period later
			ce_131k <= div_131k == '0;
			ce_vid <= div_vid == '0;
		end
	end

	// The two CPU phases must never coincide
	assert property (@(posedge clk_sys) disable iff (reset) !(ce_bus_p && ce_bus_n));

endmodule

//--- verilog/ql_reset_stretch.sv
module ql_reset_stretch #(
	parameter int RESET_CYCLES = 4095
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ce_bus_p,
	output logic core_reset
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 1);

	logic [CNT_W-1:0] count;	// Bus phases left

	always_ff @(posedge clk_sys) begin
		if (reset)
			count <= CNT_W'(RESET_CYCLES);
		else if (ce_bus_p && count != '0)
			count <= count - 1'b1;	// Count down only on Phi1
	end

	assign core_reset = count != '0;

endmodule

//--- verilog/ql_config_regs.sv
module ql_config_regs (
	input  logic                               clk_sys,
	input  logic                               core_reset,
	input  ql_cfg_pkg::ram_cfg_e               cfg_ram,
	input  ql_map_pkg::ql_region_e             region,
	input  logic                               is_wr,
	input  logic [ql_map_pkg::ADDR_W-1:1]      cpu_addr,
	input  logic                               cpu_uds,
	input  logic                               cpu_lds,
	input  logic [ql_map_pkg::DATA_W-1:0]      cpu_dout,
	output ql_cfg_pkg::ram_cfg_e               ram_cfg,
	output logic                               rom_shadow,
	output logic [7:0]                         mc_stat
);
	import ql_cfg_pkg::*;
	import ql_map_pkg::*;

	logic gc_wr;	// Upper byte write into GC I/O
	logic mc_wr;	// ZX8301 control register

	assign gc_wr = region == REG_GC_IO && is_wr && cpu_uds && !cpu_lds;
	// $18063 is only decoded on A6, A5 and A1
	assign mc_wr = region == REG_QL_IO && is_wr && cpu_lds
		&& cpu_addr[6] && cpu_addr[5] && cpu_addr[1];

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			ram_cfg <= cfg_ram;	// Size only changes across a reset
			rom_shadow <= 1'b0;	// Boot from GC ROM
			mc_stat <= 8'h00;
		end else begin
			if (gc_wr) begin
				if (cpu_addr[7:1] == 7'h30)
					rom_shadow <= 1'b1;	// $60, shadow RAM on
				else if (cpu_addr[7:1] == 7'h32)
					rom_shadow <= 1'b0;	// $64, shadow RAM off
			end
			if (mc_wr)
				mc_stat <= cpu_dout[7:0];	// Mode and screen select
		end
	end

	// GC I/O only exists in GoldCard mode, so the decoder must gate it
	assert property (@(posedge clk_sys) disable iff (core_reset)
		$rose(rom_shadow) |-> ram_cfg == RAM_4096K);

endmodule

//--- verilog/ql_addr_decode.sv
module ql_addr_decode (
	input  logic [ql_map_pkg::ADDR_W-1:1]  cpu_addr,
	input  logic                           cpu_as,
	input  logic                           cpu_rw,
	input  logic                           cpu_uds,
	input  logic                           cpu_lds,
	input  ql_cfg_pkg::ram_cfg_e           ram_cfg,
	input  logic                           rom_shadow,
	output ql_map_pkg::ql_region_e         region,
	output logic [ql_map_pkg::ADDR_W-1:0]  mem_addr,
	output logic                           is_rd,
	output logic                           is_wr,
	output logic                           sdram_we,
	output logic                           sdram_oe,
	output logic                           vram_we,
	output logic                           zx8302_sel,
	output logic                           qimi_sel,
	output logic                           qlsd_sel
);
	import ql_cfg_pkg::*;
	import ql_map_pkg::*;

	logic [ADDR_W-1:0] addr_mask;
	logic [ADDR_W-1:0] xram_end;
	logic gc_en;	// GoldCard mode
	logic qlsd_en;	// QL-SD visible in ROM space
	logic is_ram;
	logic is_io;

	function automatic logic in_range(
		input logic [ADDR_W-1:0] a,
		input logic [ADDR_W-1:0] base,
		input logic [ADDR_W-1:0] size
	);
		return a >= base && a < base + size;
	endfunction

	always_comb begin
		unique case (ram_cfg)
			RAM_128K: begin
				addr_mask = MASK_128K;
				xram_end = XRAM_BASE;	// Empty range
			end
			RAM_640K: begin
				addr_mask = MASK_1M;
				xram_end = XRAM_END_640K;
			end
			RAM_896K: begin
				addr_mask = MASK_1M;
				xram_end = XRAM_END_896K;
			end
			RAM_4096K: begin
				addr_mask = MASK_8M;
				xram_end = XRAM_END_4096K;
			end
		endcase
	end

	// Byte bit from strobes, lower strobe alone means odd byte
	assign mem_addr = {cpu_addr, !cpu_uds && cpu_lds} & addr_mask;

	assign is_rd = cpu_as && cpu_rw && (cpu_uds || cpu_lds);
	assign is_wr = cpu_as && !cpu_rw && (cpu_uds || cpu_lds);
	assign is_io = is_rd || is_wr;
	assign gc_en = ram_cfg == RAM_4096K;
	assign qlsd_en = (!gc_en || rom_shadow) && is_rd;

	assign is_ram = in_range(mem_addr, BRAM_BASE, BRAM_SIZE)
		|| (mem_addr >= XRAM_BASE && mem_addr < xram_end)
		|| (gc_en && in_range(mem_addr, GC_RAM1_BASE, GC_RAM1_SIZE))
		|| (gc_en && in_range(mem_addr, GC_RAM2_BASE, GC_RAM2_SIZE));

	// ========================================
	// Region priority
	// ========================================

	always_comb begin
		region = REG_NONE;
		if (in_range(mem_addr, '0, EXT_ROM_BASE))
			region = REG_OS_ROM;
		else if (qlsd_en && in_range(mem_addr, QLSD_REG_BASE, QLSD_REG_SIZE))
			region = REG_QLSD_REG;
		else if (qlsd_en && in_range(mem_addr, QLSD_DAT_BASE, QLSD_DAT_SIZE))
			region = REG_QLSD_DAT;
		else if (in_range(mem_addr, EXT_ROM_BASE, EXT_ROM_SIZE))
			region = REG_EXT_ROM;
		else if (in_range(mem_addr, QL_IO_BASE, QL_IO_SIZE))
			region = REG_QL_IO;
		else if (gc_en && in_range(mem_addr, GC_IO_BASE, GC_IO_SIZE))
			region = REG_GC_IO;
		else if (gc_en && !rom_shadow && in_range(mem_addr, GC_BOOT_BASE, GC_BOOT_SIZE))
			region = REG_GC_BOOT;	// Boot copy hides RAM until shadow is on
		else if (gc_en && in_range(mem_addr, GC_OS_BASE, GC_OS_SIZE))
			region = REG_GC_OS_ROM;
		else if (is_ram)
			region = REG_RAM;
	end

	// OS ROM area is shadow RAM, written while booting, read once enabled
	assign sdram_we = is_wr && (region == REG_RAM || (region == REG_OS_ROM && !rom_shadow));
	assign sdram_oe = is_rd && (region == REG_RAM || (region == REG_OS_ROM && rom_shadow));
	assign vram_we = is_wr && in_range(mem_addr, VRAM_BASE, VRAM_SIZE);

	assign zx8302_sel = is_io && region == REG_QL_IO && !mem_addr[6];
	assign qimi_sel = is_io && region == REG_QL_IO && &mem_addr[13:8];	// $1BFxx
	assign qlsd_sel = region == REG_QLSD_REG || region == REG_QLSD_DAT;

endmodule

//--- verilog/ql_read_mux.sv
module ql_read_mux (
	input  logic                           clk_sys,
	input  logic                           cpu_as,
	input  ql_map_pkg::ql_region_e         region,
	input  ql_cfg_pkg::ram_cfg_e           ram_cfg,
	input  logic                           rom_shadow,
	input  logic [ql_map_pkg::ADDR_W-1:1]  cpu_addr,
	input  logic                           sdram_we,
	input  logic                           sdram_oe,
	input  logic [ql_map_pkg::DATA_W-1:0]  ql_rom_q,
	input  logic [ql_map_pkg::DATA_W-1:0]  gc_rom_q,
	input  logic [ql_map_pkg::DATA_W-1:0]  sdram_q,
	input  logic [ql_map_pkg::DATA_W-1:0]  zx8302_q,
	input  logic [7:0]                     qimi_q,
	input  logic [7:0]                     qlsd_q,
	input  logic                           sdram_dtack,
	input  logic                           qlsd_dtack,
	output logic [ql_map_pkg::DATA_W-1:0]  cpu_din,
	output logic                           cpu_dtack
);
	import ql_cfg_pkg::*;
	import ql_map_pkg::*;

	logic qlsd_rd;	// $FEE4 read
	logic rom_win;	// Anywhere in $0000-$FFFF
	logic [DATA_W-1:0] io_q;

	assign qlsd_rd = region == REG_QLSD_REG && cpu_addr[15:1] == QLSD_RD_ADDR[15:1];
	assign rom_win = region inside {REG_OS_ROM, REG_EXT_ROM, REG_QLSD_REG, REG_QLSD_DAT};

	always_comb begin
		if (&cpu_addr[13:8])
			io_q = {qimi_q, qimi_q};	// 8 bit device on both lanes
		else if (!cpu_addr[6])
			io_q = zx8302_q;
		else
			io_q = '0;
	end

	// ========================================
	// Read data
	// ========================================

	always_comb begin
		cpu_din = '1;	// Open bus
		if (region == REG_QL_IO) begin
			cpu_din = io_q;
		end else if (ram_cfg != RAM_4096K) begin
			if (qlsd_rd)
				cpu_din = {qlsd_q, qlsd_q};
			else if (rom_win)
				cpu_din = ql_rom_q;	// OS plus ext ROM
			else if (region == REG_RAM)
				cpu_din = sdram_q;
		end else if (!rom_shadow) begin
			if (rom_win || region == REG_GC_BOOT)
				cpu_din = gc_rom_q;	// Boot from GC ROM
			else if (region == REG_GC_OS_ROM)
				cpu_din = ql_rom_q;
			else if (region == REG_RAM)
				cpu_din = sdram_q;
		end else begin
			if (region == REG_OS_ROM || region == REG_RAM)
				cpu_din = sdram_q;	// Shadowed OS
			else if (qlsd_rd)
				cpu_din = {qlsd_q, qlsd_q};
			else if (rom_win || region == REG_GC_OS_ROM)
				cpu_din = ql_rom_q;
		end
	end

	always_comb begin
		if (region == REG_QLSD_REG || region == REG_QLSD_DAT)
			cpu_dtack = qlsd_dtack;
		else if (sdram_we || sdram_oe)
			cpu_dtack = sdram_dtack;	// Held low until SDRAM is done
		else
			cpu_dtack = 1'b1;
	end

	// Decoder strobes and slave dtacks must all resolve during a cycle
	assert property (@(posedge clk_sys) cpu_as |-> !$isunknown(cpu_dtack));

endmodule

//--- verilog/ql_bus.sv
module ql_bus #(
	parameter int DIV_BUS_QL   = ql_cfg_pkg::DIV_BUS_QL_DEF,
	parameter int DIV_BUS_16   = ql_cfg_pkg::DIV_BUS_16_DEF,
	parameter int DIV_BUS_24   = ql_cfg_pkg::DIV_BUS_24_DEF,
	parameter int DIV_BUS_FULL = ql_cfg_pkg::DIV_BUS_FULL_DEF,
	parameter int DIV_131K     = ql_cfg_pkg::DIV_131K_DEF,
	parameter int DIV_VID      = ql_cfg_pkg::DIV_VID_DEF,
	parameter int RESET_CYCLES = 4095
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  ql_cfg_pkg::ram_cfg_e           cfg_ram,
	input  ql_cfg_pkg::cpu_speed_e         cfg_speed,
	input  logic [ql_map_pkg::ADDR_W-1:1]  cpu_addr,	// Word address
	input  logic                           cpu_as,
	input  logic                           cpu_rw,
	input  logic                           cpu_uds,
	input  logic                           cpu_lds,
	input  logic [ql_map_pkg::DATA_W-1:0]  cpu_dout,
	input  logic [ql_map_pkg::DATA_W-1:0]  ql_rom_q,
	input  logic [ql_map_pkg::DATA_W-1:0]  gc_rom_q,
	input  logic [ql_map_pkg::DATA_W-1:0]  sdram_q,
	input  logic [ql_map_pkg::DATA_W-1:0]  zx8302_q,
	input  logic [7:0]                     qimi_q,
	input  logic [7:0]                     qlsd_q,
	input  logic                           sdram_dtack,
	input  logic                           qlsd_dtack,
	output logic                           ce_bus_p,
	output logic                           ce_bus_n,
	output logic                           ce_131k,
	output logic                           ce_vid,
	output logic                           core_reset,
	output logic [ql_map_pkg::DATA_W-1:0]  cpu_din,
	output logic                           cpu_dtack,
	output logic [ql_map_pkg::ADDR_W-1:0]  mem_addr,
	output logic                           sdram_we,
	output logic                           sdram_oe,
	output logic                           vram_we,
	output logic                           zx8302_sel,
	output logic                           qimi_sel,
	output logic                           qlsd_sel,
	output logic [7:0]                     mc_stat
);
	import ql_cfg_pkg::*;
	import ql_map_pkg::*;

	ram_cfg_e ram_cfg;	// Latched at reset
	ql_region_e region;
	logic rom_shadow;
	logic is_wr;

	ql_clock_enables #(
		.DIV_BUS_QL(DIV_BUS_QL), .DIV_BUS_16(DIV_BUS_16), .DIV_BUS_24(DIV_BUS_24),
		.DIV_BUS_FULL(DIV_BUS_FULL), .DIV_131K(DIV_131K), .DIV_VID(DIV_VID)
	) ql_clock_enables_i (
		.clk_sys, .reset, .cpu_speed(cfg_speed), .ce_bus_p, .ce_bus_n, .ce_131k, .ce_vid
	);

	ql_reset_stretch #(.RESET_CYCLES(RESET_CYCLES)) ql_reset_stretch_i (
		.clk_sys, .reset, .ce_bus_p, .core_reset
	);

	ql_config_regs ql_config_regs_i (
		.clk_sys, .core_reset, .cfg_ram, .region, .is_wr, .cpu_addr, .cpu_uds,
		.cpu_lds, .cpu_dout, .ram_cfg, .rom_shadow, .mc_stat
	);

	// Read strobe stays local to the decoder
	ql_addr_decode ql_addr_decode_i (
		.cpu_addr, .cpu_as, .cpu_rw, .cpu_uds, .cpu_lds, .ram_cfg, .rom_shadow,
		.region, .mem_addr, .is_rd(), .is_wr, .sdram_we, .sdram_oe, .vram_we,
		.zx8302_sel, .qimi_sel, .qlsd_sel
	);

	ql_read_mux ql_read_mux_i (
		.clk_sys, .cpu_as, .region, .ram_cfg, .rom_shadow, .cpu_addr, .sdram_we,
		.sdram_oe, .ql_rom_q, .gc_rom_q, .sdram_q, .zx8302_q, .qimi_q, .qlsd_q,
		.sdram_dtack, .qlsd_dtack, .cpu_din, .cpu_dtack
	);

endmodule

//--- include/ql_bus_tb_table.svh
`ifndef QL_BUS_TB_TABLE_SVH
`define QL_BUS_TB_TABLE_SVH

// One bus access and what the core should answer
typedef struct packed {
	ql_cfg_pkg::ram_cfg_e ram;
	logic        wr;
	logic [23:0] addr;	// Byte address
	logic [1:0]  strb;	// {uds, lds}
	logic [15:0] wdata;
	logic [15:0] exp_din;
	logic        exp_dtack;
	logic        exp_we;
	logic        exp_oe;
	logic [7:0]  exp_stat;	// mc_stat once the access is done
	logic [3:0]  exp_sel;	// {vram_we, zx8302_sel, qimi_sel, qlsd_sel}
} bus_step_t;

localparam ql_cfg_pkg::ram_cfg_e T128 = ql_cfg_pkg::RAM_128K;
localparam ql_cfg_pkg::ram_cfg_e T640 = ql_cfg_pkg::RAM_640K;
localparam ql_cfg_pkg::ram_cfg_e T896 = ql_cfg_pkg::RAM_896K;
localparam ql_cfg_pkg::ram_cfg_e T4M  = ql_cfg_pkg::RAM_4096K;

localparam int TB_STEPS = 24;

localparam bus_step_t TB_TABLE [TB_STEPS] = '{
	'{T128, 1'b0, 24'h000000, 2'b11, 16'h0000, 16'h1111, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// OS ROM
	'{T128, 1'b0, 24'h00FEE4, 2'b11, 16'h0000, 16'h6666, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0001},	// QL-SD
	'{T128, 1'b0, 24'h020000, 2'b11, 16'h0000, 16'h3333, 1'b1, 1'b0, 1'b1, 8'h00, 4'b0000},	// Base RAM
	'{T128, 1'b0, 24'h018020, 2'b11, 16'h0000, 16'h4444, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0100},	// ZX8302
	'{T128, 1'b0, 24'h01BF00, 2'b11, 16'h0000, 16'h5555, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0110},	// QIMI
	'{T128, 1'b0, 24'h010000, 2'b11, 16'h0000, 16'hFFFF, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// Unmapped
	'{T128, 1'b0, 24'h040000, 2'b11, 16'h0000, 16'h1111, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// Wraps
	'{T128, 1'b1, 24'h020000, 2'b11, 16'h1234, 16'h3333, 1'b1, 1'b1, 1'b0, 8'h00, 4'b1000},
	'{T128, 1'b1, 24'h018063, 2'b01, 16'h00A5, 16'h0000, 1'b1, 1'b0, 1'b0, 8'hA5, 4'b0000},	// MC_STAT
	'{T128, 1'b0, 24'h018020, 2'b11, 16'h0000, 16'h4444, 1'b1, 1'b0, 1'b0, 8'hA5, 4'b0100},
	'{T640, 1'b0, 24'h080000, 2'b11, 16'h0000, 16'h3333, 1'b1, 1'b0, 1'b1, 8'h00, 4'b0000},
	'{T640, 1'b0, 24'h0C0000, 2'b11, 16'h0000, 16'hFFFF, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},
	'{T896, 1'b0, 24'h0C0000, 2'b11, 16'h0000, 16'h3333, 1'b1, 1'b0, 1'b1, 8'h00, 4'b0000},
	'{T896, 1'b0, 24'h100000, 2'b11, 16'h0000, 16'h1111, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// Wraps
	'{T4M,  1'b0, 24'h000000, 2'b11, 16'h0000, 16'h2222, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// GC boot
	'{T4M,  1'b0, 24'h040000, 2'b11, 16'h0000, 16'h2222, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},
	'{T4M,  1'b0, 24'h400000, 2'b11, 16'h0000, 16'h1111, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},
	'{T4M,  1'b1, 24'h01C060, 2'b10, 16'h0000, 16'hFFFF, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// Shadow on
	'{T4M,  1'b0, 24'h000000, 2'b11, 16'h0000, 16'h3333, 1'b1, 1'b0, 1'b1, 8'h00, 4'b0000},
	'{T4M,  1'b1, 24'h000100, 2'b11, 16'hBEEF, 16'h3333, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},
	'{T4M,  1'b0, 24'h00FEE4, 2'b11, 16'h0000, 16'h6666, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0001},
	'{T4M,  1'b1, 24'h01C064, 2'b10, 16'h0000, 16'hFFFF, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},	// Shadow off
	'{T4M,  1'b0, 24'h000000, 2'b11, 16'h0000, 16'h2222, 1'b1, 1'b0, 1'b0, 8'h00, 4'b0000},
	'{T4M,  1'b1, 24'h000100, 2'b11, 16'hBEEF, 16'h2222, 1'b1, 1'b1, 1'b0, 8'h00, 4'b0000}
};

`endif

//--- test/ql_bus_tb.sv
module ql_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ql_cfg_pkg::*;
	import ql_map_pkg::*;

	`include "ql_bus_tb_table.svh"

	localparam int WAIT_LIMIT = 1000;	// Cycles per wait loop
	localparam int STRETCH = 16;	// RESET_CYCLES of the DUT
	localparam int WINDOW = 132;	// Enable count window

	logic clk_sys;
	logic reset;
	ram_cfg_e cfg_ram;
	cpu_speed_e cfg_speed;
	logic [ADDR_W-1:1] cpu_addr;
	logic cpu_as;
	logic cpu_rw;
	logic cpu_uds;
	logic cpu_lds;
	logic [DATA_W-1:0] cpu_dout;
	logic [DATA_W-1:0] ql_rom_q;
	logic [DATA_W-1:0] gc_rom_q;
	logic [DATA_W-1:0] sdram_q;
	logic [DATA_W-1:0] zx8302_q;
	logic [7:0] qimi_q;
	logic [7:0] qlsd_q;
	logic sdram_dtack;
	logic qlsd_dtack;
	logic ce_bus_p;
	logic ce_bus_n;
	logic ce_131k;
	logic ce_vid;
	logic core_reset;
	logic [DATA_W-1:0] cpu_din;
	logic cpu_dtack;
	logic [ADDR_W-1:0] mem_addr;
	logic sdram_we;
	logic sdram_oe;
	logic vram_we;
	logic zx8302_sel;
	logic qimi_sel;
	logic qlsd_sel;
	logic [7:0] mc_stat;

	ql_bus #(.RESET_CYCLES(STRETCH)) ql_bus_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;	// 100 MHz
	end

	// ========================================
	// Checks
	// ========================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_stat(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			fail_run($sformatf("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// Bus period in clk_sys cycles, 84 MHz defaults
	function automatic int bus_period(input cpu_speed_e speed);
		case (speed)
			SPEED_QL: return DIV_BUS_QL_DEF;
			SPEED_16: return DIV_BUS_16_DEF;
			SPEED_24: return DIV_BUS_24_DEF;
			default:  return DIV_BUS_FULL_DEF;
		endcase
	endfunction

	// Byte address wrap, 256 KB, 1 MB or 8 MB
	function automatic logic [ADDR_W-1:0] wrap_mask(input ram_cfg_e ram);
		case (ram)
			RAM_128K:  return 24'h03FFFF;
			RAM_4096K: return 24'h7FFFFF;
			default:   return 24'h0FFFFF;
		endcase
	endfunction

	// ========================================
	// Sequences
	// ========================================

	// Reset with a new RAM size, then count Phi1 pulses of the stretch
	task automatic reset_core(input ram_cfg_e ram);
		int pulses;
		int n;
		@(posedge clk_sys);
		cfg_ram <= ram;
		reset <= 1'b1;
		repeat (8) @(posedge clk_sys);
		check_flag(core_reset, 1'b1, "core_reset during reset");
		reset <= 1'b0;
		pulses = 0;
		n = 0;
		@(negedge clk_sys);
		while (core_reset && n < WAIT_LIMIT) begin
			if (ce_bus_p)
				pulses++;	// Consumed at the next edge
			n++;
			@(negedge clk_sys);
		end
		if (core_reset)
			fail_run("Timed out waiting for core_reset to fall after reset");
		check_count(pulses, STRETCH, "ce_bus_p pulses in reset stretch");
	endtask

	// Switch speed, lock onto Phi1, then count over a fixed window
	task automatic count_enables(input cpu_speed_e speed);
		int pulses;
		int n;
		@(posedge clk_sys);
		cfg_speed <= speed;
		repeat (2) begin	// Second pulse is on the new period
			n = 0;
			@(negedge clk_sys);
			while (!ce_bus_p && n < WAIT_LIMIT) begin
				n++;
				@(negedge clk_sys);
			end
			if (!ce_bus_p)
				fail_run($sformatf("No ce_bus_p pulse seen at speed %s", speed.name()));
		end
		pulses = 0;
		for (n = 0; n < WINDOW; n++) begin
			@(negedge clk_sys);
			if (ce_bus_p)
				pulses++;
			check_flag(ce_bus_p && ce_bus_n, 1'b0, "ce_bus_p with ce_bus_n");
		end
		check_count(pulses, WINDOW / bus_period(speed), $sformatf("ce_bus_p count at %s",
			speed.name()));
	endtask

	// Gap between two pulses of ce_vid, or of ce_131k when slow is set
	task automatic check_enable_gap(input bit slow, input int period, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!(slow ? ce_131k : ce_vid) && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk_sys);
		end
		if (!(slow ? ce_131k : ce_vid))
			fail_run($sformatf("No %s pulse seen", what));
		n = 1;
		@(negedge clk_sys);
		while (!(slow ? ce_131k : ce_vid) && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk_sys);
		end
		if (!(slow ? ce_131k : ce_vid))
			fail_run($sformatf("Timed out waiting for a second %s pulse", what));
		check_count(n, period, {what, " period"});
	endtask

	// One table access, checked once DTACK is seen
	task automatic run_step(input int idx, input bus_step_t s);
		int n;
		string tag;
		tag = $sformatf("step %0d", idx);
		@(posedge clk_sys);
		cpu_addr <= s.addr[ADDR_W-1:1];
		cpu_as <= 1'b1;
		cpu_rw <= !s.wr;
		cpu_uds <= s.strb[1];
		cpu_lds <= s.strb[0];
		cpu_dout <= s.wdata;
		@(posedge clk_sys);
		@(negedge clk_sys);
		n = 0;
		while (!cpu_dtack && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk_sys);
		end
		if (!cpu_dtack)
			fail_run($sformatf("Timed out waiting for cpu_dtack in %s", tag));
		check_word(cpu_din, s.exp_din, {tag, " cpu_din"});
		check_flag(cpu_dtack, s.exp_dtack, {tag, " cpu_dtack"});
		check_flag(sdram_we, s.exp_we, {tag, " sdram_we"});
		check_flag(sdram_oe, s.exp_oe, {tag, " sdram_oe"});
		check_stat(mc_stat, s.exp_stat, {tag, " mc_stat"});
		check_addr(mem_addr, s.addr & wrap_mask(s.ram), {tag, " mem_addr"});
		check_flag(vram_we, s.exp_sel[3], {tag, " vram_we"});
		check_flag(zx8302_sel, s.exp_sel[2], {tag, " zx8302_sel"});
		check_flag(qimi_sel, s.exp_sel[1], {tag, " qimi_sel"});
		check_flag(qlsd_sel, s.exp_sel[0], {tag, " qlsd_sel"});
		@(posedge clk_sys);
		cpu_as <= 1'b0;	// Bus idle between accesses
		cpu_rw <= 1'b1;
		cpu_uds <= 1'b0;
		cpu_lds <= 1'b0;
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		ram_cfg_e cur;
		reset = 1'b1;
		cfg_ram = TB_TABLE[0].ram;
		cfg_speed = SPEED_QL;
		cpu_addr = '0;
		cpu_as = 1'b0;
		cpu_rw = 1'b1;
		cpu_uds = 1'b0;
		cpu_lds = 1'b0;
		cpu_dout = '0;
		ql_rom_q = 16'h1111;	// Distinct per source
		gc_rom_q = 16'h2222;
		sdram_q = 16'h3333;
		zx8302_q = 16'h4444;
		qimi_q = 8'h55;
		qlsd_q = 8'h66;
		sdram_dtack = 1'b1;
		qlsd_dtack = 1'b1;

		reset_core(TB_TABLE[0].ram);
		count_enables(SPEED_QL);
		count_enables(SPEED_16);
		count_enables(SPEED_24);
		count_enables(SPEED_FULL);
		check_enable_gap(1'b0, DIV_VID_DEF, "ce_vid");
		check_enable_gap(1'b1, DIV_131K_DEF, "ce_131k");

		cur = TB_TABLE[0].ram;
		for (int i = 0; i < TB_STEPS; i++) begin
			if (TB_TABLE[i].ram != cur) begin
				reset_core(TB_TABLE[i].ram);	// Size is latched only in reset
				cur = TB_TABLE[i].ram;
			end
			run_step(i, TB_TABLE[i]);
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- ql_bus.f
+incdir+include
verilog/ql_cfg_pkg.sv
verilog/ql_map_pkg.sv
verilog/ql_clock_enables.sv
verilog/ql_reset_stretch.sv
verilog/ql_config_regs.sv
verilog/ql_addr_decode.sv
verilog/ql_read_mux.sv
verilog/ql_bus.sv
test/ql_bus_tb.sv
